// File: run.sh
#!/bin/sh
# build and run the UDP transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module udpTxTb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VudpTxTb +verilator+error+limit+100 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// File: source/crc32Byte.sv
`timescale 1ns/1ps

module crc32Byte
    import netProtoPkg::*;
(
    input  logic        I_clk50m,
    input  logic        I_rst,
    input  logic        crcInit,
    input  logic        crcOn,
    input  logic        byteTaken,
    input  byteT        txByte,
    output logic [31:0] fcs
);

    localparam logic [31:0] POLY      = 32'h04C11DB7;
    // lsb-first form of the generator
    localparam logic [31:0] POLY_REFL = {<<{POLY}};

    logic [31:0] crcReg;
    logic [31:0] crcNext;

    // eight shift steps unrolled into one xor network
    function automatic logic [31:0] crcStep(input logic [31:0] crc, input byteT data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crcNext = crcStep(crcReg, txByte);

    always_ff @(posedge I_clk50m or negedge I_rst) begin
        if (!I_rst) begin
            crcReg <= '1;
        end else if (crcInit) begin
            crcReg <= '1;
        end else if (crcOn && byteTaken) begin
            crcReg <= crcNext;
        end
    end

    // register is already reflected, so byte 0 here is the first one on the wire
    assign fcs = ~crcReg;

endmodule

// File: source/frameSequencer.sv
`timescale 1ns/1ps

module frameSequencer
    import netProtoPkg::*, rmiiPhyPkg::*;
#(
    parameter macAddrT srcMac  = 48'd0,
    parameter macAddrT dstMac  = 48'd0,
    parameter ipAddrT  srcIp   = 32'd0,
    parameter ipAddrT  dstIp   = 32'd0,
    parameter wordT    srcPort = 16'd0,
    parameter wordT    dstPort = 16'd0
)(
    input  logic        I_clk50m,
    input  logic        I_rst,
    input  logic        I_en,
    input  byteT        I_data,
    input  wordT        I_dataLen,
    input  wordT        I_ipv4sign,
    input  logic        byteTaken,
    input  logic        dibitActive,
    input  wordT        ipChecksum,
    input  logic [31:0] fcs,
    output byteT        txByte,
    output logic        sending,
    output logic        start,
    output logic        crcInit,
    output logic        crcOn,
    output logic        O_busy,
    output logic        O_txen,
    output logic        O_isLoadData
);

    frameSectionT state;
    frameSectionT nextSec;
    wordT         idx;
    wordT         secLast;
    wordT         totalLen;
    wordT         udpLen;

    // header fields with the msb byte at index 0
    byteT [0:5]  dstBytes;
    byteT [0:5]  srcBytes;
    byteT [0:1]  ethBytes;
    byteT [0:19] ipHdr;
    byteT [0:7]  udpHdr;
    // fcs goes out lsb byte first
    byteT [3:0]  fcsBytes;

    assign udpLen   = I_dataLen + wordT'(UDP_HDR_LEN);
    assign totalLen = udpLen + wordT'(IP_HDR_LEN);

    assign dstBytes = dstMac;
    assign srcBytes = srcMac;
    assign ethBytes = ETHTYPE_IPV4;
    assign ipHdr    = {IP_VER_IHL, 8'h00, totalLen, I_ipv4sign, IP_FLAGS_FRAG,
                       IP_TTL, IP_PROTO_UDP, ipChecksum, srcIp, dstIp};
    assign udpHdr   = {srcPort, dstPort, udpLen, 16'h0000};
    assign fcsBytes = fcs;

    // section length and successor
    always_comb begin
        secLast = '0;
        nextSec = IDLE;
        case (state)
            PREAMBLE: begin
                secLast = wordT'(PREAMBLE_LEN) - 16'd1;
                nextSec = SFD;
            end
            SFD: begin
                secLast = '0;
                nextSec = DSTMAC;
            end
            DSTMAC: begin
                secLast = 16'd5;
                nextSec = SRCMAC;
            end
            SRCMAC: begin
                secLast = 16'd5;
                nextSec = ETHTYPE;
            end
            ETHTYPE: begin
                secLast = 16'd1;
                nextSec = IPHDR;
            end
            IPHDR: begin
                secLast = wordT'(IP_HDR_LEN) - 16'd1;
                nextSec = UDPHDR;
            end
            UDPHDR: begin
                secLast = wordT'(UDP_HDR_LEN) - 16'd1;
                nextSec = PAYLOAD;
            end
            PAYLOAD: begin
                secLast = I_dataLen - 16'd1;
                nextSec = FCS;
            end
            FCS: begin
                secLast = wordT'(FCS_LEN) - 16'd1;
                nextSec = GAP;
            end
            default: begin
                secLast = '0;
                nextSec = IDLE;
            end
        endcase
    end

    always_ff @(posedge I_clk50m or negedge I_rst) begin
        if (!I_rst) begin
            state <= IDLE;
            idx   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    idx <= '0;
                    if (I_en) begin
                        state <= PREAMBLE;
                    end
                end
                GAP: begin
                    // count only once the last dibit has left the line
                    if (!dibitActive) begin
                        if (idx == wordT'(GAP_CLKS) - 16'd1) begin
                            idx   <= '0;
                            state <= IDLE;
                        end else begin
                            idx <= idx + 16'd1;
                        end
                    end
                end
                default: begin
                    if (byteTaken) begin
                        if (idx == secLast) begin
                            idx   <= '0;
                            state <= nextSec;
                        end else begin
                            idx <= idx + 16'd1;
                        end
                    end
                end
            endcase
        end
    end

    // outgoing byte mux
    always_comb begin
        case (state)
            PREAMBLE: txByte = PREAMBLE_BYTE;
            SFD:      txByte = SFD_BYTE;
            DSTMAC:   txByte = dstBytes[idx[2:0]];
            SRCMAC:   txByte = srcBytes[idx[2:0]];
            ETHTYPE:  txByte = ethBytes[idx[0]];
            IPHDR:    txByte = ipHdr[idx[4:0]];
            UDPHDR:   txByte = udpHdr[idx[2:0]];
            PAYLOAD:  txByte = I_data;
            FCS:      txByte = fcsBytes[idx[1:0]];
            default:  txByte = '0;
        endcase
    end

    assign sending      = (state != IDLE) && (state != GAP);
    assign start        = (state == IDLE) && I_en;
    assign crcInit      = (state == SFD) && byteTaken;
    assign crcOn        = state inside {DSTMAC, SRCMAC, ETHTYPE, IPHDR, UDPHDR, PAYLOAD};
    assign O_isLoadData = (state == PAYLOAD) && byteTaken;
    assign O_busy       = (state != IDLE);

    // serializer keeps shifting the last fcs byte after sending drops
    assign O_txen = dibitActive;

endmodule

// File: source/ipv4Checksum.sv
`timescale 1ns/1ps

module ipv4Checksum
    import netProtoPkg::*;
#(
    parameter ipAddrT srcIp = 32'd0,
    parameter ipAddrT dstIp = 32'd0
)(
    input  logic I_clk50m,
    input  logic I_rst,
    input  logic start,
    input  wordT I_dataLen,
    input  wordT I_ipv4sign,
    output wordT ipChecksum
);

    wordT        totalLen;
    logic [19:0] rawSum;
    logic [19:0] sumReg;
    logic        foldPending;

    assign totalLen = I_dataLen + wordT'(IP_HDR_LEN) + wordT'(UDP_HDR_LEN);

    // ten header words with the checksum field counted as zero
    assign rawSum = 20'({IP_VER_IHL, 8'h00}) + 20'(totalLen) + 20'(I_ipv4sign)
                  + 20'(IP_FLAGS_FRAG) + 20'({IP_TTL, IP_PROTO_UDP})
                  + 20'(srcIp[31:16]) + 20'(srcIp[15:0])
                  + 20'(dstIp[31:16]) + 20'(dstIp[15:0]);

    always_ff @(posedge I_clk50m or negedge I_rst) begin
        if (!I_rst) begin
            foldPending <= 1'b0;
        end else begin
            foldPending <= start;
        end
    end

    // first carry fold is registered
    always_ff @(posedge I_clk50m) begin
        if (start) begin
            sumReg <= rawSum;
        end else if (foldPending) begin
            sumReg <= 20'(sumReg[15:0]) + 20'(sumReg[19:16]);
        end
    end

    // second fold cannot carry again
    assign ipChecksum = ~(sumReg[15:0] + wordT'(sumReg[19:16]));

endmodule

// File: source/netProtoPkg.sv
package netProtoPkg;

    // basic field widths
    typedef logic [7:0]  byteT;
    typedef logic [15:0] wordT;
    typedef logic [31:0] ipAddrT;
    typedef logic [47:0] macAddrT;

    // frame sections in the order they go out on the wire
    typedef enum logic [3:0] {
        IDLE,
        PREAMBLE,
        SFD,
        DSTMAC,
        SRCMAC,
        ETHTYPE,
        IPHDR,
        UDPHDR,
        PAYLOAD,
        FCS,
        GAP
    } frameSectionT;

    // ethernet framing
    localparam byteT       PREAMBLE_BYTE = 8'h55;
    localparam byteT       SFD_BYTE      = 8'hD5;
    localparam logic [7:0] PREAMBLE_LEN  = 8'd7;
    localparam wordT       ETHTYPE_IPV4  = 16'h0800;

    // ipv4 header fields, no options
    localparam byteT       IP_VER_IHL    = 8'h45;
    // don't fragment, offset zero
    localparam wordT       IP_FLAGS_FRAG = 16'h4000;
    localparam byteT       IP_TTL        = 8'h40;
    localparam byteT       IP_PROTO_UDP  = 8'h11;

    // section lengths in bytes
    localparam logic [7:0] IP_HDR_LEN    = 8'd20;
    localparam logic [7:0] UDP_HDR_LEN   = 8'd8;
    localparam logic [7:0] FCS_LEN       = 8'd4;

endpackage

// File: source/rmiiPhyPkg.sv
package rmiiPhyPkg;

    // one RMII symbol per clock
    typedef logic [1:0] dibitT;

    // four dibits make one byte
    localparam logic [2:0] CLKS_PER_BYTE = 3'd4;

    // interframe gap, 96 bit times at two bits per clock
    localparam logic [7:0] GAP_CLKS = 8'd48;

endpackage

// File: source/rmiiSerializer.sv
`timescale 1ns/1ps

module rmiiSerializer
    import netProtoPkg::*, rmiiPhyPkg::*;
(
    input  logic  I_clk50m,
    input  logic  I_rst,
    input  logic  sending,
    input  byteT  txByte,
    output logic  byteTaken,
    output dibitT O_txd,
    output logic  dibitActive
);

    localparam logic [1:0] LAST_PHASE = 2'(CLKS_PER_BYTE - 3'd1);

    byteT       shiftReg;
    logic [1:0] phase;
    logic       active;

    // take a byte on the last dibit of the previous one, or straight away from idle
    assign byteTaken = sending && (!active || phase == LAST_PHASE);

    always_ff @(posedge I_clk50m or negedge I_rst) begin
        if (!I_rst) begin
            active <= 1'b0;
            phase  <= 2'd0;
        end else if (byteTaken) begin
            active <= 1'b1;
            phase  <= 2'd0;
        end else if (active) begin
            phase <= phase + 2'd1;
            // nothing queued, line goes quiet after this dibit
            if (phase == LAST_PHASE) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge I_clk50m) begin
        if (byteTaken) begin
            shiftReg <= txByte;
        end else begin
            shiftReg <= {dibitT'(0), shiftReg[7:2]};
        end
    end

    // lsb dibit first
    assign O_txd       = active ? shiftReg[1:0] : dibitT'(0);
    assign dibitActive = active;

endmodule

// File: source/udpTxTop.sv
`timescale 1ns/1ps

module udpTxTop
    import netProtoPkg::*, rmiiPhyPkg::*;
#(
    parameter macAddrT srcMac  = 48'd0,
    parameter macAddrT dstMac  = 48'd0,
    parameter ipAddrT  srcIp   = 32'd0,
    parameter ipAddrT  dstIp   = 32'd0,
    parameter wordT    srcPort = 16'd0,
    parameter wordT    dstPort = 16'd0
)(
    input  logic  I_clk50m,
    input  logic  I_rst,
    input  logic  I_en,
    input  byteT  I_data,
    input  wordT  I_dataLen,
    input  wordT  I_ipv4sign,
    output dibitT O_txd,
    output logic  O_txen,
    output logic  O_busy,
    output logic  O_isLoadData
);

    byteT        txByte;
    logic        sending;
    logic        byteTaken;
    logic        dibitActive;
    logic        start;
    logic        crcInit;
    logic        crcOn;
    wordT        ipChecksum;
    logic [31:0] fcs;

    frameSequencer #(
        .srcMac (srcMac),
        .dstMac (dstMac),
        .srcIp  (srcIp),
        .dstIp  (dstIp),
        .srcPort(srcPort),
        .dstPort(dstPort)
    ) sequencer (
        .I_clk50m    (I_clk50m),
        .I_rst       (I_rst),
        .I_en        (I_en),
        .I_data      (I_data),
        .I_dataLen   (I_dataLen),
        .I_ipv4sign  (I_ipv4sign),
        .byteTaken   (byteTaken),
        .dibitActive (dibitActive),
        .ipChecksum  (ipChecksum),
        .fcs         (fcs),
        .txByte      (txByte),
        .sending     (sending),
        .start       (start),
        .crcInit     (crcInit),
        .crcOn       (crcOn),
        .O_busy      (O_busy),
        .O_txen      (O_txen),
        .O_isLoadData(O_isLoadData)
    );

    ipv4Checksum #(
        .srcIp(srcIp),
        .dstIp(dstIp)
    ) checksum (
        .I_clk50m  (I_clk50m),
        .I_rst     (I_rst),
        .start     (start),
        .I_dataLen (I_dataLen),
        .I_ipv4sign(I_ipv4sign),
        .ipChecksum(ipChecksum)
    );

    crc32Byte crc (
        .I_clk50m (I_clk50m),
        .I_rst    (I_rst),
        .crcInit  (crcInit),
        .crcOn    (crcOn),
        .byteTaken(byteTaken),
        .txByte   (txByte),
        .fcs      (fcs)
    );

    rmiiSerializer serializer (
        .I_clk50m   (I_clk50m),
        .I_rst      (I_rst),
        .sending    (sending),
        .txByte     (txByte),
        .byteTaken  (byteTaken),
        .O_txd      (O_txd),
        .dibitActive(dibitActive)
    );

endmodule

// File: testbench/udpTxTb.sv
`timescale 1ns/1ps

module udpTxTb
    import netProtoPkg::*, rmiiPhyPkg::*;
();

    localparam macAddrT testDstMac  = 48'hF0E1D2C3B4A5;
    localparam macAddrT testSrcMac  = 48'h0A1B2C3D4E5F;
    localparam ipAddrT  testSrcIp   = 32'hC0A80102;
    localparam ipAddrT  testDstIp   = 32'hC0A80164;
    localparam wordT    testSrcPort = 16'h1388;
    localparam wordT    testDstPort = 16'h1770;

    logic  I_clk50m = 1'b0;
    logic  I_rst;
    logic  I_en;
    byteT  I_data;
    wordT  I_dataLen;
    wordT  I_ipv4sign;
    dibitT O_txd;
    logic  O_txen;
    logic  O_busy;
    logic  O_isLoadData;

    logic [31:0] lfsrState;
    logic [31:0] dataBits;
    byteT        rxShift = 8'h00;
    int          rxDibits = 0;
    byteT        rxBytes[$];
    byteT        payloadQ[$];
    byteT        expQ[$];

    udpTxTop #(
        .srcMac (testSrcMac),
        .dstMac (testDstMac),
        .srcIp  (testSrcIp),
        .dstIp  (testDstIp),
        .srcPort(testSrcPort),
        .dstPort(testDstPort)
    ) UUT (
        .I_clk50m    (I_clk50m),
        .I_rst       (I_rst),
        .I_en        (I_en),
        .I_data      (I_data),
        .I_dataLen   (I_dataLen),
        .I_ipv4sign  (I_ipv4sign),
        .O_txd       (O_txd),
        .O_txen      (O_txen),
        .O_busy      (O_busy),
        .O_isLoadData(O_isLoadData)
    );

    bind udpTxTop udpTx_props props (
        .I_clk50m    (I_clk50m),
        .I_rst       (I_rst),
        .I_en        (I_en),
        .O_txd       (O_txd),
        .O_txen      (O_txen),
        .O_busy      (O_busy),
        .O_isLoadData(O_isLoadData)
    );

    always #10 I_clk50m = ~I_clk50m;

    // galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return {1'b0, s[31:1]} ^ 32'hA3000000;
        end
        return {1'b0, s[31:1]};
    endfunction

    task automatic drawBits(input int nBits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nBits; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timeout: %s, the frame never arrived", what);
        $display("Result: FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic reportProtocolFailure();
        $display("a protocol assertion on the DUT ports failed");
        $display("Result: FAILED");
        $fatal(1, "protocol assertion failed");
    endtask

    // msb byte first
    task automatic appendField(input logic [47:0] value, input int nBytes);
        for (int i = nBytes - 1; i >= 0; i--) begin
            expQ.push_back(byteT'(value >> (8 * i)));
        end
    endtask

    function automatic wordT headerChecksum(input wordT totalLen, input wordT ident);
        logic [31:0] sum;
        sum = 32'h4500 + 32'(totalLen) + 32'(ident) + 32'h4000 + 32'h4011
            + 32'(testSrcIp[31:16]) + 32'(testSrcIp[15:0])
            + 32'(testDstIp[31:16]) + 32'(testDstIp[15:0]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        return ~sum[15:0];
    endfunction

    // reflected 0x04C11DB7, one bit at a time
    function automatic logic [31:0] frameCrc(input int first, input int last);
        logic [31:0] crc;
        byteT        d;
        crc = 32'hFFFFFFFF;
        for (int i = first; i <= last; i++) begin
            d = expQ[i];
            for (int b = 0; b < 8; b++) begin
                if (crc[0] ^ d[0]) begin
                    crc = (crc >> 1) ^ 32'hEDB88320;
                end else begin
                    crc = crc >> 1;
                end
                d = d >> 1;
            end
        end
        return ~crc;
    endfunction

    // new payload candidate every cycle
    always @(posedge I_clk50m) begin
        #1;
        if (I_rst) begin
            drawBits(8, dataBits);
            I_data = dataBits[7:0];
        end
    end

    // RMII receiver, dibits lsb first
    always @(negedge I_clk50m) begin
        if (O_txen) begin
            rxShift  = {O_txd, rxShift[7:2]};
            rxDibits = rxDibits + 1;
            if (rxDibits == 4) begin
                rxBytes.push_back(rxShift);
                rxDibits = 0;
            end
        end else begin
            rxDibits = 0;
        end
        if (O_isLoadData) begin
            payloadQ.push_back(I_data);
        end
    end

    always @(negedge I_clk50m) begin
        if (UUT.props.failCount != 0) begin
            reportProtocolFailure();
        end
    end

    task automatic runFrame(input int frameNo, input wordT len, input wordT ident);
        string       tag;
        int          base;
        int          payBase;
        int          cycles;
        int          doneSize;
        logic [31:0] crc;
        logic [31:0] sum;
        tag     = $sformatf("frame%0d", frameNo);
        base    = rxBytes.size();
        payBase = payloadQ.size();

        @(posedge I_clk50m);
        #1;
        I_dataLen  = len;
        I_ipv4sign = ident;
        I_en       = 1'b1;
        @(posedge I_clk50m);
        #1;
        I_en = 1'b0;
        @(negedge I_clk50m);
        checkValue({tag, " busy after start"}, 32'd1, 32'(O_busy));

        // this pulse lands while busy and must be ignored
        @(posedge I_clk50m);
        #1;
        I_en = 1'b1;
        @(posedge I_clk50m);
        #1;
        I_en = 1'b0;

        cycles = 0;
        while (!O_txen && cycles < 100) begin
            @(negedge I_clk50m);
            cycles++;
        end
        if (!O_txen) begin
            reportTimeout({tag, " O_txen never rose"});
        end
        cycles = 0;
        while (O_txen && cycles < 2000) begin
            @(negedge I_clk50m);
            cycles++;
        end
        if (O_txen) begin
            reportTimeout({tag, " O_txen never fell"});
        end
        cycles = 0;
        while (O_busy && cycles < 200) begin
            @(negedge I_clk50m);
            cycles++;
        end
        if (O_busy) begin
            reportTimeout({tag, " O_busy never fell"});
        end
        checkValue({tag, " gap cycles"}, 32'(GAP_CLKS), 32'(cycles));

        checkValue({tag, " payload strobes"}, 32'(int'(len)), 32'(payloadQ.size() - payBase));
        checkValue({tag, " frame length"}, 32'(54 + int'(len)), 32'(rxBytes.size() - base));

        expQ = {};
        repeat (7) expQ.push_back(8'h55);
        expQ.push_back(8'hD5);
        appendField(testDstMac, 6);
        appendField(testSrcMac, 6);
        appendField(48'h0800, 2);
        appendField(48'h4500, 2);
        appendField(48'(len + 16'd28), 2);
        appendField(48'(ident), 2);
        appendField(48'h40004011, 4);
        appendField(48'(headerChecksum(len + 16'd28, ident)), 2);
        appendField(48'(testSrcIp), 4);
        appendField(48'(testDstIp), 4);
        appendField(48'(testSrcPort), 2);
        appendField(48'(testDstPort), 2);
        appendField(48'(len + 16'd8), 2);
        appendField(48'h0000, 2);
        for (int k = 0; k < int'(len); k++) begin
            expQ.push_back(payloadQ[payBase + k]);
        end
        crc = frameCrc(8, expQ.size() - 1);
        for (int i = 0; i < 4; i++) begin
            expQ.push_back(byteT'(crc >> (8 * i)));
        end

        for (int i = 0; i < expQ.size(); i++) begin
            checkValue($sformatf("%s byte %0d", tag, i), 32'(expQ[i]), 32'(rxBytes[base + i]));
        end

        // received ip header must sum to all ones
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 32'({rxBytes[base + 22 + 2 * i], rxBytes[base + 23 + 2 * i]});
        end
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        checkValue({tag, " ip header sum"}, 32'h0000FFFF, sum);

        // no second frame from the ignored pulse
        doneSize = rxBytes.size();
        repeat (100) begin
            @(negedge I_clk50m);
            checkValue({tag, " idle after gap"}, 32'd0, 32'(O_busy));
        end
        checkValue({tag, " no extra bytes"}, 32'(doneSize), 32'(rxBytes.size()));
    endtask

    initial begin
        logic [31:0] bits;
        wordT        ident1;
        wordT        ident2;
        wordT        len2;
        lfsrState  = 32'h48131334;
        I_rst      = 1'b0;
        I_en       = 1'b0;
        I_data     = 8'h00;
        I_dataLen  = 16'd0;
        I_ipv4sign = 16'd0;

        drawBits(16, bits);
        ident1 = bits[15:0];
        drawBits(16, bits);
        ident2 = bits[15:0];
        drawBits(6, bits);
        len2 = 16'(32'd18 + bits % 32'd47);

        repeat (3) @(posedge I_clk50m);
        #1;
        I_rst = 1'b1;
        @(negedge I_clk50m);
        checkValue("reset txen", 32'd0, 32'(O_txen));
        checkValue("reset busy", 32'd0, 32'(O_busy));
        checkValue("reset loadData", 32'd0, 32'(O_isLoadData));
        checkValue("reset txd", 32'd0, 32'(O_txd));

        runFrame(1, 16'd20, ident1);
        runFrame(2, len2, ident2);

        if (UUT.props.failCount == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            reportProtocolFailure();
        end
    end

endmodule

// File: testbench/udpTx_props.sv
`timescale 1ns/1ps

module udpTx_props
    import rmiiPhyPkg::*;
(
    input logic  I_clk50m,
    input logic  I_rst,
    input logic  I_en,
    input dibitT O_txd,
    input logic  O_txen,
    input logic  O_busy,
    input logic  O_isLoadData
);

    // read by the testbench top
    int failCount = 0;

    txenInsideBusy: assert property (
        @(posedge I_clk50m) disable iff (!I_rst) O_txen |-> O_busy
    ) else begin
        $error("O_txen is high while O_busy is low");
        failCount++;
    end

    // payload is only fetched while a byte is on the line
    loadInsideTxen: assert property (
        @(posedge I_clk50m) disable iff (!I_rst) O_isLoadData |-> O_txen
    ) else begin
        $error("O_isLoadData is high while O_txen is low");
        failCount++;
    end

    quietLine: assert property (
        @(posedge I_clk50m) disable iff (!I_rst) !O_txen |-> (O_txd == 2'b00)
    ) else begin
        $error("O_txd is not zero while O_txen is low");
        failCount++;
    end

    startFromIdle: assert property (
        @(posedge I_clk50m) disable iff (!I_rst) (I_en && !O_busy) |=> O_busy
    ) else begin
        $error("I_en in idle did not raise O_busy on the next edge");
        failCount++;
    end

endmodule

// File: verilog.f
source/netProtoPkg.sv
source/rmiiPhyPkg.sv
source/rmiiSerializer.sv
source/crc32Byte.sv
source/ipv4Checksum.sv
source/frameSequencer.sv
source/udpTxTop.sv
testbench/udpTx_props.sv
testbench/udpTxTb.sv
